/* include/switch_settings.svh */
`ifndef SWITCH_SETTINGS_SVH
`define SWITCH_SETTINGS_SVH

// switch geometry
`define N_PORTS      3
`define MTU          64
`define STORE_FRAMES 8    // must stay a power of two

// idle cycles after every frame slot on the output side
`define IFG_TICKS    4

// 32-bit Galois LFSR, x^32 + x^22 + x^2 + x + 1
`define LFSR_SEED    32'h1d872b41
`define LFSR_TAPS    32'h80200003

// a frame is kept when the LFSR value is below this limit (about 3/4 kept)
`define DROP_LIMIT   32'hc0000000

`endif

/* verilog/frame_pkg.sv */
`default_nettype none

`include "switch_settings.svh"

package frame_pkg;

  typedef logic [7:0] byte_t;

  // one extra bit so that a full MTU-byte frame length fits
  typedef logic [$clog2(`MTU + 1)-1:0] flen_t;

  typedef logic [$clog2(`STORE_FRAMES)-1:0] slot_t;

endpackage

`default_nettype wire

/* verilog/switch_pkg.sv */
`default_nettype none

`include "switch_settings.svh"

package switch_pkg;

  typedef logic [`N_PORTS-1:0] port_mask_t;

  typedef logic [$clog2(`N_PORTS)-1:0] port_idx_t;

  typedef enum logic [1:0] {
    w_idle,
    w_stage,
    w_commit
  } wr_state_t;

  typedef enum logic [1:0] {
    r_idle,
    r_send,
    r_gap
  } rd_state_t;

endpackage

`default_nettype wire

/* verilog/frame_commit_if.sv */
`default_nettype none
`timescale 1ns/1ps

interface frame_commit_if;
  import frame_pkg::*;

  logic  req;   // frame staged, waiting for or inside a commit
  byte_t data;
  logic  last;  // marks the final byte of the frame
  logic  gnt;   // one-cycle grant pulse from the store

  modport writer (
    output req,
    output data,
    output last,
    input  gnt
  );

  modport store (
    input  req,
    input  data,
    input  last,
    output gnt
  );

endinterface

`default_nettype wire

/* verilog/ingress_capture.sv */
`default_nettype none
`timescale 1ns/1ps

`include "switch_settings.svh"

module ingress_capture (
  input  logic                                   clk,
  input  logic                                   rst,
  input  frame_pkg::byte_t [`N_PORTS-1:0]        din,
  input  switch_pkg::port_mask_t                 vin,
  output frame_pkg::byte_t [`N_PORTS-1:0]        cap_data,
  output switch_pkg::port_mask_t                 cap_start,
  output switch_pkg::port_mask_t                 cap_end
);
  import frame_pkg::*;
  import switch_pkg::*;

  port_mask_t vin_q;
  port_mask_t vin_prev;

  // bytes are only meaningful while the matching valid is high
  always_ff @(posedge clk) begin
    cap_data <= din;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vin_q    <= '0;
      vin_prev <= '0;
    end else begin
      vin_q    <= vin;
      vin_prev <= vin_q;
    end
  end

  // start lines up with the first registered byte of the frame
  assign cap_start = vin_q & ~vin_prev;
  assign cap_end   = ~vin_q & vin_prev;  // first cycle after the final byte

endmodule

`default_nettype wire

/* verilog/port_writer.sv */
`default_nettype none
`timescale 1ns/1ps

`include "switch_settings.svh"

module port_writer (
  input  logic                  clk,
  input  logic                  rst,
  input  frame_pkg::byte_t      cap_data,
  input  logic                  cap_start,
  input  logic                  cap_end,
  frame_commit_if.writer        cm
);
  import frame_pkg::*;
  import switch_pkg::*;

  localparam int IDX_W = $clog2(`MTU);

  wr_state_t state;
  byte_t     stage_mem [`MTU];
  flen_t     len;
  flen_t     rd_idx;
  logic      req_q;
  logic      sending;
  logic      last_byte;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= w_idle;
      req_q   <= 1'b0;
      sending <= 1'b0;
    end else begin
      case (state)
        w_idle: if (cap_start) state <= w_stage;  // busy ports never get here
        w_stage: begin
          if (cap_end) begin
            state <= w_commit;
            req_q <= 1'b1;
          end
        end
        w_commit: begin
          if (cm.gnt) sending <= 1'b1;
          if (last_byte) begin
            sending <= 1'b0;
            req_q   <= 1'b0;
            state   <= w_idle;
          end
        end
        default: state <= w_idle;
      endcase
    end
  end

  // staging keeps the first MTU bytes and drops the rest
  always_ff @(posedge clk) begin
    if (state == w_idle && cap_start) begin
      stage_mem[0] <= cap_data;
      len          <= flen_t'(1);
    end else if (state == w_stage && !cap_end && len != flen_t'(`MTU)) begin
      stage_mem[len[IDX_W-1:0]] <= cap_data;
      len                       <= len + 1'b1;
    end
    if (cm.gnt) rd_idx <= '0;
    else if (sending) rd_idx <= rd_idx + 1'b1;
  end

  assign last_byte = sending && (rd_idx == len - 1'b1);

  assign cm.req  = req_q;
  assign cm.data = stage_mem[rd_idx[IDX_W-1:0]];
  assign cm.last = last_byte;

  // the store relies on a full frame ahead of every release of req
  a_req_holds: assert property (@(posedge clk) disable iff (rst)
    $fell(cm.req) |-> $past(last_byte));

endmodule

`default_nettype wire

/* verilog/drop_lfsr.sv */
`default_nettype none
`timescale 1ns/1ps

`include "switch_settings.svh"

module drop_lfsr (
  input  logic clk,
  input  logic rst,
  input  logic step,
  output logic keep
);

  logic [31:0] lfsr;

  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr <= `LFSR_SEED;
    end else if (step) begin
      lfsr <= {1'b0, lfsr[31:1]} ^ ({32{lfsr[0]}} & `LFSR_TAPS);  // right-shift Galois
    end
  end

  assign keep = lfsr < `DROP_LIMIT;

  // a zero state would lock the generator and freeze the loss pattern
  a_never_zero: assert property (@(posedge clk) disable iff (rst) lfsr != '0);

endmodule

`default_nettype wire

/* verilog/frame_store.sv */
`default_nettype none
`timescale 1ns/1ps

`include "switch_settings.svh"

module frame_store (
  input  logic                             clk,
  input  logic                             rst,
  frame_commit_if.store                    cm [`N_PORTS],
  output frame_pkg::byte_t [`N_PORTS-1:0]  dout,
  output switch_pkg::port_mask_t           vout
);
  import frame_pkg::*;
  import switch_pkg::*;

  localparam int IDX_W  = $clog2(`MTU);
  localparam int SLOT_W = $clog2(`STORE_FRAMES);
  localparam int GAP_W  = $clog2(`IFG_TICKS + 1);

  port_mask_t            req_v;
  port_mask_t            last_v;
  port_mask_t            gnt_v;
  byte_t [`N_PORTS-1:0]  data_v;

  byte_t     mem [`STORE_FRAMES][`MTU];
  flen_t     len_mem [`STORE_FRAMES];
  port_idx_t src_mem [`STORE_FRAMES];

  logic [SLOT_W:0] wptr;  // top bit tells full from empty
  logic [SLOT_W:0] rptr;
  slot_t           wslot;
  slot_t           rslot;
  logic            full;
  logic            empty;

  port_idx_t  rr_last;
  port_idx_t  cur;
  port_idx_t  pick;
  logic       pick_ok;
  logic       recv;
  logic       can_grant;
  flen_t      widx;

  rd_state_t        rd_state;
  flen_t            ridx;
  flen_t            rlen;
  logic             kept;
  logic             keep;
  logic             frame_done;
  port_mask_t       src_mask;
  logic [GAP_W-1:0] gap_cnt;

  for (genvar g = 0; g < `N_PORTS; g++) begin : g_cm
    assign req_v[g]  = cm[g].req;
    assign last_v[g] = cm[g].last;
    assign data_v[g] = cm[g].data;
    assign cm[g].gnt = gnt_v[g];
  end

  assign wslot = wptr[SLOT_W-1:0];
  assign rslot = rptr[SLOT_W-1:0];
  assign empty = (wptr == rptr);
  assign full  = (wptr[SLOT_W] != rptr[SLOT_W]) && (wslot == rslot);

  // round robin, search starts just after the port granted last
  always_comb begin
    int idx;
    pick    = rr_last;
    pick_ok = 1'b0;
    for (int k = 1; k <= `N_PORTS; k++) begin
      idx = (int'(rr_last) + k) % `N_PORTS;
      if (!pick_ok && req_v[idx]) begin
        pick    = port_idx_t'(idx);
        pick_ok = 1'b1;
      end
    end
  end

  assign can_grant = !recv && (gnt_v == '0) && !full;

  always_ff @(posedge clk) begin
    if (rst) begin
      gnt_v   <= '0;
      recv    <= 1'b0;
      cur     <= '0;
      rr_last <= port_idx_t'(`N_PORTS - 1);
      wptr    <= '0;
    end else begin
      gnt_v <= '0;
      if (can_grant && pick_ok) begin
        gnt_v   <= port_mask_t'(1) << pick;
        cur     <= pick;
        rr_last <= pick;
      end
      if (|gnt_v) begin
        recv <= 1'b1;  // bytes start on the next cycle
      end else if (recv && last_v[cur]) begin
        recv <= 1'b0;
        wptr <= wptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (|gnt_v) begin
      widx <= '0;
    end else if (recv) begin
      mem[wslot][widx[IDX_W-1:0]] <= data_v[cur];
      widx                        <= widx + 1'b1;
      if (last_v[cur]) begin
        len_mem[wslot] <= widx + 1'b1;
        src_mem[wslot] <= cur;
      end
    end
  end

  drop_lfsr lfsr_i (
    .clk  (clk),
    .rst  (rst),
    .step (frame_done),
    .keep (keep)
  );

  assign frame_done = (rd_state == r_send) && (ridx == rlen - 1'b1);

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state <= r_idle;
      rptr     <= '0;
      vout     <= '0;
    end else begin
      vout <= '0;
      case (rd_state)
        r_idle: if (!empty) rd_state <= r_send;
        r_send: begin
          vout <= kept ? ~src_mask : '0;  // a dropped frame still takes its cycles
          if (frame_done) begin
            rd_state <= r_gap;
            rptr     <= rptr + 1'b1;
          end
        end
        r_gap: if (gap_cnt == GAP_W'(`IFG_TICKS - 1)) rd_state <= r_idle;
        default: rd_state <= r_idle;
      endcase
    end
  end

  // frame attributes are sampled in the idle cycle before sending
  always_ff @(posedge clk) begin
    dout <= {`N_PORTS{mem[rslot][ridx[IDX_W-1:0]]}};
    if (rd_state == r_idle) begin
      ridx     <= '0;
      rlen     <= len_mem[rslot];
      kept     <= keep;
      src_mask <= port_mask_t'(1) << src_mem[rslot];
      gap_cnt  <= '0;
    end else if (rd_state == r_send) begin
      ridx <= ridx + 1'b1;
    end else begin
      gap_cnt <= gap_cnt + 1'b1;
    end
  end

  // a grant only ever reaches a writer that is still requesting
  a_gnt_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(gnt_v) && (gnt_v & ~req_v) == '0);

  // the source recorded with the slot being read stays silent
  a_no_echo: assert property (@(posedge clk) disable iff (rst)
    |vout |-> !vout[$past(src_mem[rslot])]);

  a_no_gnt_full: assert property (@(posedge clk) disable iff (rst)
    |gnt_v |-> $past((SLOT_W + 1)'(wptr - rptr)) < `STORE_FRAMES);

endmodule

`default_nettype wire

/* verilog/switch_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "switch_settings.svh"

module switch_top (
  input  logic                             clk,
  input  logic                             rst,
  input  frame_pkg::byte_t [`N_PORTS-1:0]  din,
  input  switch_pkg::port_mask_t           vin,
  output frame_pkg::byte_t [`N_PORTS-1:0]  dout,
  output switch_pkg::port_mask_t           vout
);
  import frame_pkg::*;
  import switch_pkg::*;

  byte_t [`N_PORTS-1:0] cap_data;
  port_mask_t           cap_start;
  port_mask_t           cap_end;

  frame_commit_if cm_if [`N_PORTS] ();

  ingress_capture capture_i (
    .clk       (clk),
    .rst       (rst),
    .din       (din),
    .vin       (vin),
    .cap_data  (cap_data),
    .cap_start (cap_start),
    .cap_end   (cap_end)
  );

  for (genvar p = 0; p < `N_PORTS; p++) begin : g_port
    port_writer writer_i (
      .clk       (clk),
      .rst       (rst),
      .cap_data  (cap_data[p]),
      .cap_start (cap_start[p]),
      .cap_end   (cap_end[p]),
      .cm        (cm_if[p])
    );
  end

  frame_store store_i (
    .clk  (clk),
    .rst  (rst),
    .cm   (cm_if),
    .dout (dout),
    .vout (vout)
  );

endmodule

`default_nettype wire

/* sim/switch_tb.sv */
`default_nettype none
`timescale 1ns/1ps

`include "switch_settings.svh"

module switch_tb;
  import frame_pkg::*;
  import switch_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int N_RANDOM   = 16;
  localparam int QUIET      = 2 * (`MTU + `IFG_TICKS + 2);  // idle watch after the last frame

  typedef struct packed {
    int port;
    int len;
    int first;     // frame bytes count up from this value
    int gap;       // cycles from this frame's start to the next frame's start
    bit accepted;  // low when the port is still busy with its previous frame
  } frame_row_t;

  logic                 clk;
  logic                 rst;
  byte_t [`N_PORTS-1:0] din;
  port_mask_t           vin;
  byte_t [`N_PORTS-1:0] dout;
  port_mask_t           vout;

  frame_row_t frames[$];
  int         start_cyc[$];
  int         exp_q[$];  // kept frames in output order, as indices into frames
  int         wd_cycles = 0;
  bit         inputs_started = 1'b0;
  bit         in_frame = 1'b0;

  switch_top uut (
    .clk  (clk),
    .rst  (rst),
    .din  (din),
    .vin  (vin),
    .dout (dout),
    .vout (vout)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_on_failure();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    if (exp !== act) begin
      $display("ERR %0t %s expected %02h got %02h", $time, name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_mask(input string name, input port_mask_t exp, input port_mask_t act);
    if (exp !== act) begin
      $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_len(input string name, input flen_t exp, input flen_t act);
    if (exp !== act) begin
      $display("ERR %0t %s expected %0d got %0d", $time, name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic add_frame(input int port, input int len, input int first, input int gap,
                           input bit accepted);
    frame_row_t r;
    r.port     = port;
    r.len      = len;
    r.first    = first;
    r.gap      = gap;
    r.accepted = accepted;
    frames.push_back(r);
  endtask

  // right-shifting Galois step with the feedback mask from the settings header
  function automatic logic [31:0] lfsr_next(input logic [31:0] v);
    return (v >> 1) ^ (v[0] ? `LFSR_TAPS : 32'h0);
  endfunction

  // frames longer than the MTU come out cut to MTU bytes
  function automatic flen_t exp_len(input int idx);
    return flen_t'((frames[idx].len > `MTU) ? `MTU : frames[idx].len);
  endfunction

  task automatic build_model();
    int          end_cyc[$];
    bit          done[$];
    logic [31:0] lfsr;
    int          rr_last;
    int          best;
    int          pick;
    int          cyc;
    int          dropped;
    cyc     = 0;
    dropped = 0;
    foreach (frames[i]) begin
      start_cyc.push_back(cyc);
      end_cyc.push_back(cyc + frames[i].len);
      done.push_back(!frames[i].accepted);
      cyc += frames[i].gap;
    end
    lfsr    = `LFSR_SEED;
    rr_last = `N_PORTS - 1;
    do begin
      best = -1;
      pick = -1;
      foreach (frames[i]) begin
        if (!done[i] && (best < 0 || end_cyc[i] < end_cyc[best])) best = i;
      end
      if (best >= 0) begin
        // frames that end together go round robin after the port granted last
        for (int k = 1; k <= `N_PORTS; k++) begin
          foreach (frames[i]) begin
            if (pick < 0 && !done[i] && end_cyc[i] == end_cyc[best] &&
                frames[i].port == (rr_last + k) % `N_PORTS) pick = i;
          end
        end
        done[pick] = 1'b1;
        rr_last    = frames[pick].port;
        if (lfsr < `DROP_LIMIT) exp_q.push_back(pick);
        else dropped++;
        lfsr = lfsr_next(lfsr);
      end
    end while (best >= 0);
    $display("model: %0d frames kept, %0d dropped", exp_q.size(), dropped);
  endtask

  task automatic drive_frames();
    byte_t [`N_PORTS-1:0] d;
    port_mask_t           v;
    int                   total;
    int                   off;
    total = start_cyc[start_cyc.size()-1] + frames[frames.size()-1].len + 1;
    inputs_started = 1'b1;
    for (int c = 0; c <= total; c++) begin
      d = '0;
      v = '0;
      foreach (frames[i]) begin
        off = c - start_cyc[i];
        if (off >= 0 && off < frames[i].len) begin
          d[frames[i].port] = byte_t'(frames[i].first + off);
          v[frames[i].port] = 1'b1;
        end
      end
      @(posedge clk);
      din <= d;
      vin <= v;
    end
  endtask

  initial begin : monitor
    int         cur;
    port_mask_t cur_mask;
    int         cnt;
    int         idle;
    int         seen;
    cur      = 0;
    cur_mask = '0;
    cnt      = 0;
    idle     = 0;
    seen     = 0;
    forever begin
      @(negedge clk);
      if (rst || !inputs_started) begin
        check_mask("vout", '0, vout);  // quiet during reset and before any input
      end else if (vout != '0) begin
        if (!in_frame) begin
          if (exp_q.size() == 0) begin
            $display("a frame appeared on the output at %0t when none was expected", $time);
            stop_on_failure();
          end
          if (seen > 0 && idle < `IFG_TICKS) begin
            $display("only %0d idle cycles before the frame at %0t", idle, $time);
            stop_on_failure();
          end
          cur      = exp_q.pop_front();
          cur_mask = ~(port_mask_t'(1) << frames[cur].port);
          in_frame = 1'b1;
          cnt      = 0;
        end
        check_mask("vout", cur_mask, vout);
        // the source port carries the byte as well
        for (int p = 0; p < `N_PORTS; p++) begin
          check_byte($sformatf("dout[%0d]", p), byte_t'(frames[cur].first + cnt), dout[p]);
        end
        cnt++;
        idle = 0;
      end else begin
        if (in_frame) begin
          check_len("frame length", exp_len(cur), flen_t'(cnt));
          in_frame = 1'b0;
          seen++;
        end
        idle++;
      end
    end
  end

  initial begin : watchdog
    wait (wd_cycles != 0);
    repeat (wd_cycles) @(posedge clk);
    $display("watchdog expired, the run did not finish within %0d cycles", wd_cycles);
    stop_on_failure();
  end

  initial begin
    int len;
    int budget;
    rst = 1'b1;
    din = '0;
    vin = '0;
    void'($urandom(32'hf91bff64));
    add_frame(0, 16, 'h10, 50, 1'b1);  // single flooded frame, kept by the seed value
    add_frame(1, 20, 'h40, 60, 1'b1);
    // three frames ending together, so port 2 goes first after port 1
    add_frame(0, 12, 'h80, 0, 1'b1);
    add_frame(1, 12, 'h90, 0, 1'b1);
    add_frame(2, 12, 'ha0, 50, 1'b1);
    add_frame(0, 8, 'h60, 30, 1'b1);    // lands on a dropping LFSR value ahead of the oversize one
    add_frame(2, 70, 'h20, 71, 1'b1);   // oversize
    add_frame(2, 10, 'hc0, 160, 1'b0);  // arrives while port 2 is still committing
    for (int i = 0; i < N_RANDOM; i++) begin
      len = $urandom_range(1, 40);
      add_frame($urandom_range(0, `N_PORTS - 1), len, $urandom_range(0, 255),
                2 * len + 12, 1'b1);
    end
    build_model();
    budget = 4 + 6 + QUIET + 100;
    foreach (frames[i]) budget += frames[i].len + frames[i].gap + `IFG_TICKS + 8;
    wd_cycles = budget;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    repeat (6) @(posedge clk);
    drive_frames();
    while (exp_q.size() != 0 || in_frame) @(posedge clk);
    repeat (QUIET) @(posedge clk);
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+include
verilog/frame_pkg.sv
verilog/switch_pkg.sv
verilog/frame_commit_if.sv
verilog/ingress_capture.sv
verilog/port_writer.sv
verilog/drop_lfsr.sv
verilog/frame_store.sv
verilog/switch_top.sv
sim/switch_tb.sv

/* Makefile */
SRCS := $(shell grep -v '^+' flist.f) include/switch_settings.svh

.PHONY: all run clean

all: run

obj_dir/Vswitch_tb: flist.f $(SRCS)
	verilator --binary --timing --assert --top-module switch_tb -f flist.f

run: obj_dir/Vswitch_tb
	./obj_dir/Vswitch_tb | tee /dev/stderr | grep -q '^TEST OK$$'

clean:
	rm -rf obj_dir
